//--- design/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// load ports served in one cycle
`define NUM_SUPER 2

// direct-mapped, one 64-bit block per set
`define NUM_SETS 16

// outstanding misses and write-backs
`define NUM_MSHR 4

// byte address width on the processor side and on the memory bus
`define ADDR_W 32

// transaction tag returned by memory, zero means not accepted
`define MEM_TAG_W 4

`endif

//--- design/mem_bus_pkg.sv
package mem_bus_pkg;

    // commands on the split-transaction memory bus
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_e;

    // byte address as seen by the cache
    typedef struct packed {
        logic [24:0] tag;
        logic [3:0]  idx;
        // byte offset inside the 64-bit block
        logic [2:0]  bo;
    } cache_addr_t;

    // two addresses fall into the same 64-bit block
    function automatic logic same_block(cache_addr_t a, cache_addr_t b);
        return {a.tag, a.idx} == {b.tag, b.idx};
    endfunction

endpackage

//--- design/dcache_pkg.sv
package dcache_pkg;

    // what an MSHR entry was opened for
    typedef enum logic [1:0] {
        LOAD  = 2'h0,
        STORE = 2'h1,
        EVICT = 2'h2
    } mshr_inst_e;

    // MSHR entry life cycle
    typedef enum logic [1:0] {
        EMPTY     = 2'h0,
        // waiting for the bus to take the command
        ISSUE     = 2'h1,
        // command accepted, data not back yet
        WAIT_DATA = 2'h2,
        // block ready, waiting for the array write port
        FILL      = 2'h3
    } mshr_state_e;

endpackage

//--- design/dcache_ifs.sv
`timescale 1ns/10ps
`include "dcache_defs.svh"

// controller to tag/data array
interface cache_mem_if import mem_bus_pkg::*; ();
    cache_addr_t [`NUM_SUPER-1:0]        rd_addr;
    logic                                wr_en;
    cache_addr_t                         wr_addr;
    logic [63:0]                         wr_data;
    logic                                wr_dirty;
    logic [`NUM_SUPER-1:0][63:0]         rd_data;
    logic [`NUM_SUPER-1:0]               rd_hit;
    logic                                wr_hit;
    // line currently held at the index of wr_addr
    logic                                evicted_valid;
    logic                                evicted_dirty;
    cache_addr_t                         evicted_addr;
    logic [63:0]                         evicted_data;

    modport master (
        output rd_addr, wr_en, wr_addr, wr_data, wr_dirty,
        input  rd_data, rd_hit, wr_hit, evicted_valid, evicted_dirty, evicted_addr, evicted_data
    );
    modport slave (
        input  rd_addr, wr_en, wr_addr, wr_data, wr_dirty,
        output rd_data, rd_hit, wr_hit, evicted_valid, evicted_dirty, evicted_addr, evicted_data
    );
endinterface

// controller to miss handling
interface mshr_if import dcache_pkg::*, mem_bus_pkg::*; ();
    // searches: loads in 0 and 1, the store in 2
    cache_addr_t [2:0]                   search_addr;
    mshr_inst_e [2:0]                    search_type;
    // slots: loads in 0 and 1, store miss in 2, evicted line in 3
    logic [3:0]                          miss_en;
    cache_addr_t [3:0]                   miss_addr;
    logic [3:0][63:0]                    miss_data_in;
    mshr_inst_e [3:0]                    inst_type;
    logic                                stored;
    logic [2:0]                          addr_hit;
    logic [`NUM_SUPER-1:0][63:0]         miss_data;
    logic [`NUM_SUPER-1:0]               miss_data_valid;
    logic                                mem_wr;
    cache_addr_t                         mem_addr;
    logic [63:0]                         mem_data;
    logic                                mem_dirty;
    logic                                mshr_valid;

    modport master (
        output search_addr, search_type, miss_en, miss_addr, miss_data_in, inst_type, stored,
        input  addr_hit, miss_data, miss_data_valid, mem_wr, mem_addr, mem_data, mem_dirty,
               mshr_valid
    );
    modport slave (
        input  search_addr, search_type, miss_en, miss_addr, miss_data_in, inst_type, stored,
        output addr_hit, miss_data, miss_data_valid, mem_wr, mem_addr, mem_data, mem_dirty,
               mshr_valid
    );
endinterface

//--- design/dcache_controller.sv
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_controller import dcache_pkg::*, mem_bus_pkg::*; (
    cache_mem_if.master                  mem,
    mshr_if.master                       mshr,
    input  logic [`NUM_SUPER-1:0]        rd_en,
    input  cache_addr_t [`NUM_SUPER-1:0] rd_addr,
    input  logic                         wr_en,
    input  cache_addr_t                  wr_addr,
    input  logic [63:0]                  wr_data,
    output logic [`NUM_SUPER-1:0][63:0]  rd_data,
    output logic [`NUM_SUPER-1:0]        rd_valid,
    output logic                         wr_done,
    output logic                         cache_ready
);

    logic [`NUM_SUPER-1:0] load_miss;
    logic                  store_clash;
    logic                  store_sel;
    logic                  store_hit;
    logic                  store_miss;
    logic                  fill_wins;
    logic                  evict_line;

    // read ports and MSHR searches
    always_comb begin
        for (int p = 0; p < `NUM_SUPER; p++) begin
            mem.rd_addr[p] = rd_addr[p];
            mshr.search_addr[p] = rd_addr[p];
            mshr.search_type[p] = LOAD;
            // fill data being forwarded beats the array
            rd_data[p] = mshr.miss_data_valid[p] ? mshr.miss_data[p] : mem.rd_data[p];
            rd_valid[p] = rd_en[p] & (mem.rd_hit[p] | mshr.miss_data_valid[p]);
        end
        mshr.search_addr[2] = wr_addr;
        mshr.search_type[2] = STORE;
    end

    // load misses, skipping a block already pending or raised by a lower port
    always_comb begin
        logic dup;
        load_miss = '0;
        store_clash = 1'b0;
        for (int p = 0; p < `NUM_SUPER; p++) begin
            dup = 1'b0;
            for (int q = 0; q < p; q++) begin
                if (load_miss[q] && same_block(rd_addr[q], rd_addr[p]))
                    dup = 1'b1;
            end
            load_miss[p] = rd_en[p] & ~mem.rd_hit[p] & ~mshr.addr_hit[p] & ~dup;
            // a load opening the same block this cycle makes the store wait for it
            if (load_miss[p] && same_block(rd_addr[p], wr_addr))
                store_clash = 1'b1;
        end
    end

    // the store owns the write port unless its block is still in the MSHR,
    // or the MSHR is full while a fill waits (otherwise nothing could drain)
    assign store_sel  = wr_en & ~mshr.addr_hit[2] & (mshr.mshr_valid | ~mshr.mem_wr);
    assign store_hit  = store_sel & mem.wr_hit;
    assign store_miss = store_sel & ~mem.wr_hit & ~store_clash;
    assign fill_wins  = mshr.mem_wr & ~store_sel;

    assign mem.wr_en    = store_hit | fill_wins;
    assign mem.wr_addr  = store_sel ? wr_addr : mshr.mem_addr;
    assign mem.wr_data  = store_sel ? wr_data : mshr.mem_data;
    // write-back cache, so a store hit leaves the line dirty
    assign mem.wr_dirty = store_sel ? 1'b1 : mshr.mem_dirty;

    // fill lands on a dirty line of another block
    assign evict_line = fill_wins & mem.evicted_valid & mem.evicted_dirty &
                        (mem.evicted_addr.tag != mshr.mem_addr.tag);

    assign mshr.stored       = fill_wins;
    assign mshr.miss_en      = {evict_line, store_miss, load_miss};
    assign mshr.miss_addr    = {mem.evicted_addr, wr_addr, rd_addr};
    // whole-block stores, so the store data is the block
    assign mshr.miss_data_in = {mem.evicted_data, wr_data, {`NUM_SUPER{64'h0}}};
    assign mshr.inst_type    = '{EVICT, STORE, LOAD, LOAD};

    assign wr_done     = store_hit | (store_miss & mshr.mshr_valid);
    assign cache_ready = mshr.mshr_valid;

endmodule

//--- design/dcache_mem.sv
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_mem import mem_bus_pkg::*; (
    input  logic        clock,
    input  logic        arst_n,
    cache_mem_if.slave  port
);

    localparam int IDX_W = $clog2(`NUM_SETS);
    localparam int TAG_W = `ADDR_W - IDX_W - 3;

    logic [TAG_W-1:0]     tags  [`NUM_SETS];
    logic [63:0]          lines [`NUM_SETS];
    logic [`NUM_SETS-1:0] valid;
    logic [`NUM_SETS-1:0] dirty;
    logic [IDX_W-1:0]     wr_idx;
    cache_addr_t          victim;

    assign wr_idx = port.wr_addr.idx;

    // combinational reads with tag compare
    always_comb begin
        for (int p = 0; p < `NUM_SUPER; p++) begin
            port.rd_data[p] = lines[port.rd_addr[p].idx];
            port.rd_hit[p]  = valid[port.rd_addr[p].idx] &&
                              (tags[port.rd_addr[p].idx] == port.rd_addr[p].tag);
        end
    end

    assign port.wr_hit = valid[wr_idx] && (tags[wr_idx] == port.wr_addr.tag);

    // old line at the write index, block aligned
    always_comb begin
        victim.tag = tags[wr_idx];
        victim.idx = wr_idx;
        victim.bo  = 3'b0;
    end

    assign port.evicted_valid = valid[wr_idx];
    assign port.evicted_dirty = dirty[wr_idx];
    assign port.evicted_addr  = victim;
    assign port.evicted_data  = lines[wr_idx];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            dirty <= '0;
        end else if (port.wr_en) begin
            valid[wr_idx] <= 1'b1;
            dirty[wr_idx] <= port.wr_dirty;
        end
    end

    always_ff @(posedge clock) begin
        if (port.wr_en) begin
            tags[wr_idx]  <= port.wr_addr.tag;
            lines[wr_idx] <= port.wr_data;
        end
    end

endmodule

//--- design/mshr.sv
`timescale 1ns/10ps
`include "dcache_defs.svh"

module mshr import dcache_pkg::*, mem_bus_pkg::*; (
    input  logic                  clock,
    input  logic                  arst_n,
    mshr_if.slave                 port,
    output bus_command_e          proc2mem_command,
    output logic [`ADDR_W-1:0]    proc2mem_addr,
    output logic [63:0]           proc2mem_data,
    input  logic [`MEM_TAG_W-1:0] mem2proc_response,
    input  logic [63:0]           mem2proc_data,
    input  logic [`MEM_TAG_W-1:0] mem2proc_tag
);

    localparam int IDX_W = $clog2(`NUM_MSHR);

    mshr_state_e           state   [`NUM_MSHR];
    mshr_inst_e            inst    [`NUM_MSHR];
    cache_addr_t           addr    [`NUM_MSHR];
    logic [63:0]           data    [`NUM_MSHR];
    logic [`MEM_TAG_W-1:0] mem_tag [`NUM_MSHR];
    // cycles since allocation, saturating
    logic [7:0]            age     [`NUM_MSHR];

    logic [IDX_W-1:0]      slot_idx [3];
    logic [2:0]            slot_ok;
    logic                  alloc_ok;
    logic [`NUM_MSHR-1:0]  ret_hit;
    logic [IDX_W-1:0]      issue_idx;
    logic [IDX_W-1:0]      fill_idx;
    logic                  issue_found;
    logic                  fill_found;
    logic                  accept;
    logic                  retire;

    // oldest entry in a given state, lowest index on a tie
    function automatic logic [IDX_W:0] pick_oldest(mshr_state_e want);
        logic             found;
        logic [IDX_W-1:0] sel;
        found = 1'b0;
        sel = '0;
        for (int i = 0; i < `NUM_MSHR; i++) begin
            if (state[i] == want && (!found || age[i] > age[sel])) begin
                found = 1'b1;
                sel = IDX_W'(i);
            end
        end
        return {found, sel};
    endfunction

    always_comb begin
        {issue_found, issue_idx} = pick_oldest(ISSUE);
        {fill_found, fill_idx} = pick_oldest(FILL);
    end

    // free entries handed out in slot order; the store slot always reserves one
    // so cache_ready means any store miss this cycle can be taken
    always_comb begin
        logic [`NUM_MSHR-1:0] taken;
        logic                 want;
        taken = '0;
        for (int s = 0; s < 3; s++) begin
            want = (s == 2) ? 1'b1 : port.miss_en[s];
            slot_idx[s] = '0;
            slot_ok[s] = ~want;
            for (int i = `NUM_MSHR - 1; i >= 0; i--) begin
                if (want && state[i] == EMPTY && !taken[i]) begin
                    slot_idx[s] = IDX_W'(i);
                    slot_ok[s] = 1'b1;
                end
            end
            if (want && slot_ok[s])
                taken[slot_idx[s]] = 1'b1;
        end
    end

    assign alloc_ok        = &slot_ok;
    assign port.mshr_valid = alloc_ok;

    // address searches and forwarding of blocks waiting in FILL
    always_comb begin
        for (int s = 0; s < 3; s++) begin
            port.addr_hit[s] = 1'b0;
            for (int i = 0; i < `NUM_MSHR; i++) begin
                if (state[i] != EMPTY && same_block(addr[i], port.search_addr[s]))
                    port.addr_hit[s] = 1'b1;
            end
        end
        for (int p = 0; p < `NUM_SUPER; p++) begin
            port.miss_data_valid[p] = 1'b0;
            port.miss_data[p] = '0;
            for (int i = 0; i < `NUM_MSHR; i++) begin
                if (state[i] == FILL && port.search_type[p] == LOAD &&
                    same_block(addr[i], port.search_addr[p])) begin
                    port.miss_data_valid[p] = 1'b1;
                    port.miss_data[p] = data[i];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_MSHR; i++)
            ret_hit[i] = (state[i] == WAIT_DATA) && (mem2proc_tag != '0) &&
                         (mem_tag[i] == mem2proc_tag);
    end

    assign accept = issue_found & (mem2proc_response != '0);
    assign retire = fill_found & port.stored;

    // bus side: write-backs store, everything else fetches the block
    assign proc2mem_command = !issue_found ? BUS_NONE :
                              (inst[issue_idx] == EVICT) ? BUS_STORE : BUS_LOAD;
    assign proc2mem_addr    = addr[issue_idx];
    assign proc2mem_data    = data[issue_idx];

    // array side
    assign port.mem_wr    = fill_found;
    assign port.mem_addr  = addr[fill_idx];
    assign port.mem_data  = data[fill_idx];
    assign port.mem_dirty = (inst[fill_idx] == STORE);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NUM_MSHR; i++) begin
                state[i]   <= EMPTY;
                inst[i]    <= LOAD;
                mem_tag[i] <= '0;
                age[i]     <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_MSHR; i++) begin
                if (state[i] != EMPTY && age[i] != 8'hff)
                    age[i] <= age[i] + 8'd1;
                if (ret_hit[i])
                    state[i] <= FILL;
            end
            if (accept) begin
                if (inst[issue_idx] == EVICT) begin
                    state[issue_idx] <= EMPTY;
                end else begin
                    state[issue_idx]   <= WAIT_DATA;
                    mem_tag[issue_idx] <= mem2proc_response;
                end
            end
            // the retiring entry carries the displaced dirty line out
            if (retire) begin
                if (port.miss_en[3]) begin
                    state[fill_idx] <= ISSUE;
                    inst[fill_idx]  <= port.inst_type[3];
                    age[fill_idx]   <= '0;
                end else begin
                    state[fill_idx] <= EMPTY;
                end
            end
            if (alloc_ok) begin
                for (int s = 0; s < 3; s++) begin
                    if (port.miss_en[s]) begin
                        state[slot_idx[s]] <= ISSUE;
                        inst[slot_idx[s]]  <= port.inst_type[s];
                        age[slot_idx[s]]   <= '0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        // a store entry keeps its own block, which replaces the fetched one
        for (int i = 0; i < `NUM_MSHR; i++) begin
            if (ret_hit[i] && inst[i] != STORE)
                data[i] <= mem2proc_data;
        end
        if (retire && port.miss_en[3]) begin
            addr[fill_idx] <= port.miss_addr[3];
            data[fill_idx] <= port.miss_data_in[3];
        end
        if (alloc_ok) begin
            for (int s = 0; s < 3; s++) begin
                if (port.miss_en[s]) begin
                    addr[slot_idx[s]] <= {port.miss_addr[s].tag, port.miss_addr[s].idx, 3'b0};
                    data[slot_idx[s]] <= port.miss_data_in[s];
                end
            end
        end
    end

endmodule

//--- design/dcache_top.sv
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_top import mem_bus_pkg::*; (
    input  logic                               clock,
    input  logic                               arst_n,
    // load ports
    input  logic [`NUM_SUPER-1:0]              rd_en,
    input  logic [`NUM_SUPER-1:0][`ADDR_W-1:0] rd_addr,
    output logic [`NUM_SUPER-1:0][63:0]        rd_data,
    output logic [`NUM_SUPER-1:0]              rd_valid,
    // store port
    input  logic                               wr_en,
    input  logic [`ADDR_W-1:0]                 wr_addr,
    input  logic [63:0]                        wr_data,
    output logic                               wr_done,
    output logic                               cache_ready,
    // memory bus
    output bus_command_e                       proc2mem_command,
    output logic [`ADDR_W-1:0]                 proc2mem_addr,
    output logic [63:0]                        proc2mem_data,
    input  logic [`MEM_TAG_W-1:0]              mem2proc_response,
    input  logic [63:0]                        mem2proc_data,
    input  logic [`MEM_TAG_W-1:0]              mem2proc_tag
);

    cache_mem_if array_bus ();
    mshr_if      miss_bus ();

    dcache_controller ctrl_i (
        .mem         (array_bus.master),
        .mshr        (miss_bus.master),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .wr_done     (wr_done),
        .cache_ready (cache_ready)
    );

    dcache_mem mem_i (
        .clock  (clock),
        .arst_n (arst_n),
        .port   (array_bus.slave)
    );

    mshr mshr_i (
        .clock             (clock),
        .arst_n            (arst_n),
        .port              (miss_bus.slave),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .proc2mem_data     (proc2mem_data),
        .mem2proc_response (mem2proc_response),
        .mem2proc_data     (mem2proc_data),
        .mem2proc_tag      (mem2proc_tag)
    );

endmodule

//--- testbench/mem_model.sv
`timescale 1ns/10ps
`include "dcache_defs.svh"

// behavioral memory on the split-transaction bus, holds the low 2 KB
module mem_model import mem_bus_pkg::*; (
    input  logic                  clock,
    input  logic                  arst_n,
    input  bus_command_e          proc2mem_command,
    input  logic [`ADDR_W-1:0]    proc2mem_addr,
    input  logic [63:0]           proc2mem_data,
    output logic [`MEM_TAG_W-1:0] mem2proc_response,
    output logic [63:0]           mem2proc_data,
    output logic [`MEM_TAG_W-1:0] mem2proc_tag
);

    localparam int BLOCKS = 256;
    localparam int TAGS   = 1 << `MEM_TAG_W;

    logic [63:0]           mem       [BLOCKS];
    int                    load_cnt  [BLOCKS];
    int                    store_cnt [BLOCKS];
    // reads in flight, indexed by bus tag
    logic                  pend      [TAGS];
    int                    pend_due  [TAGS];
    logic [63:0]           pend_data [TAGS];
    int                    cycle;
    int                    blk;
    logic [`MEM_TAG_W-1:0] next_tag;

    initial begin
        // response delays come from one fixed seed
        void'($urandom(32'h1f5abde8));
        for (int b = 0; b < BLOCKS; b++) begin
            mem[b] = {53'h0, b[7:0], 3'b000} ^ 64'h5a5a_0000_a5a5_0000;
            load_cnt[b] = 0;
            store_cnt[b] = 0;
        end
        cycle = 0;
        next_tag = 1;
        mem2proc_response = '0;
        mem2proc_data = '0;
        mem2proc_tag = '0;
        forever begin
            @(negedge clock);
            cycle++;
            mem2proc_response = '0;
            mem2proc_tag = '0;
            if (!arst_n) begin
                next_tag = 1;
                for (int t = 0; t < TAGS; t++)
                    pend[t] = 1'b0;
            end else begin
                // at most one finished read goes back per cycle
                for (int t = 1; t < TAGS; t++) begin
                    if (pend[t] && pend_due[t] <= cycle && mem2proc_tag == '0) begin
                        mem2proc_tag = t[`MEM_TAG_W-1:0];
                        mem2proc_data = pend_data[t];
                        pend[t] = 1'b0;
                    end
                end
                // every command is taken at once, tag zero is never handed out
                if (proc2mem_command != BUS_NONE) begin
                    blk = proc2mem_addr[10:3];
                    mem2proc_response = next_tag;
                    if (proc2mem_command == BUS_LOAD) begin
                        load_cnt[blk]++;
                        pend[next_tag] = 1'b1;
                        pend_due[next_tag] = cycle + 2 + ($urandom % 11);
                        pend_data[next_tag] = mem[blk];
                    end else begin
                        store_cnt[blk]++;
                        mem[blk] = proc2mem_data;
                    end
                    next_tag = (next_tag == TAGS - 1) ? 1 : next_tag + 1;
                end
            end
        end
    end

endmodule

//--- testbench/dcache_tb.sv
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_tb import mem_bus_pkg::*; ();

    localparam int          LIMIT    = 200;
    localparam logic [7:0]  NO_CHECK = 8'hff;
    localparam logic [63:0] PATTERN  = 64'h5a5a_0000_a5a5_0000;

    typedef enum logic [2:0] {
        OP_LOAD0, OP_LOAD1, OP_DUAL, OP_STORE, OP_BURST, OP_DRAIN
    } op_e;

    // one table row, counts refer to addr0
    typedef struct packed {
        op_e         op;
        logic [31:0] addr0;
        logic [31:0] addr1;
        logic [63:0] data;
        logic [7:0]  exp_loads;
        logic [7:0]  exp_stores;
        logic        chk_busy;
    } row_t;

    logic                               clock;
    logic                               arst_n;
    logic [`NUM_SUPER-1:0]              rd_en;
    logic [`NUM_SUPER-1:0][`ADDR_W-1:0] rd_addr;
    logic [`NUM_SUPER-1:0][63:0]        rd_data;
    logic [`NUM_SUPER-1:0]              rd_valid;
    logic                               wr_en;
    logic [`ADDR_W-1:0]                 wr_addr;
    logic [63:0]                        wr_data;
    logic                               wr_done;
    logic                               cache_ready;
    bus_command_e                       proc2mem_command;
    logic [`ADDR_W-1:0]                 proc2mem_addr;
    logic [63:0]                        proc2mem_data;
    logic [`MEM_TAG_W-1:0]              mem2proc_response;
    logic [63:0]                        mem2proc_data;
    logic [`MEM_TAG_W-1:0]              mem2proc_tag;

    row_t        rows [$];
    row_t        cur;
    logic [63:0] ref_mem [256];
    logic        ready_low_seen;
    int          errors;
    int          checks;
    int          errs_before;

    dcache_top dut_i (
        .clock             (clock),
        .arst_n            (arst_n),
        .rd_en             (rd_en),
        .rd_addr           (rd_addr),
        .rd_data           (rd_data),
        .rd_valid          (rd_valid),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .wr_done           (wr_done),
        .cache_ready       (cache_ready),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .proc2mem_data     (proc2mem_data),
        .mem2proc_response (mem2proc_response),
        .mem2proc_data     (mem2proc_data),
        .mem2proc_tag      (mem2proc_tag)
    );

    mem_model bus_mem_i (
        .clock             (clock),
        .arst_n            (arst_n),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .proc2mem_data     (proc2mem_data),
        .mem2proc_response (mem2proc_response),
        .mem2proc_data     (mem2proc_data),
        .mem2proc_tag      (mem2proc_tag)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    function automatic int block_of(logic [31:0] a);
        return a[10:3];
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout: waited %0d cycles for %s, at %0t ns", LIMIT, what, $time);
    endtask

    task automatic add_row(input op_e op, input logic [31:0] a0, input logic [31:0] a1,
                           input logic [63:0] d, input logic [7:0] loads,
                           input logic [7:0] stores, input logic busy);
        row_t r;
        r.op = op;
        r.addr0 = a0;
        r.addr1 = a1;
        r.data = d;
        r.exp_loads = loads;
        r.exp_stores = stores;
        r.chk_busy = busy;
        rows.push_back(r);
    endtask

    // idle inputs, so cache_ready here means one free MSHR entry
    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clock);
        #2;
        while (!cache_ready && n < LIMIT) begin
            @(negedge clock);
            #2;
            n++;
        end
        if (!cache_ready)
            report_timeout("cache_ready before a request");
    endtask

    task automatic run_loads(input logic [1:0] mask, input logic [31:0] a0,
                             input logic [31:0] a1, input logic burst);
        logic [1:0]  got;
        logic [63:0] seen [2];
        logic [31:0] addr [2];
        int          n;
        got = ~mask;
        n = 0;
        addr[0] = a0;
        addr[1] = a1;
        @(negedge clock);
        rd_addr[0] = a0;
        rd_addr[1] = a1;
        rd_en = mask;
        while (got != 2'b11 && n < LIMIT) begin
            #2;
            if (burst) begin
                // both misses go into the MSHR at the next edge
                if (cache_ready)
                    got = 2'b11;
                else
                    ready_low_seen = 1'b1;
            end else begin
                for (int p = 0; p < 2; p++) begin
                    if (!got[p] && rd_valid[p]) begin
                        got[p] = 1'b1;
                        seen[p] = rd_data[p];
                    end
                end
            end
            @(negedge clock);
            rd_en = mask & ~got;
            n++;
        end
        rd_en = 2'b00;
        if (got != 2'b11) begin
            report_timeout(burst ? "cache_ready during a load burst" : "rd_valid on a load");
        end else if (!burst) begin
            for (int p = 0; p < 2; p++) begin
                if (mask[p])
                    check_value(seen[p], ref_mem[block_of(addr[p])],
                                $sformatf("load on port %0d from %h", p, addr[p]));
            end
        end
    endtask

    task automatic run_store(input logic [31:0] a, input logic [63:0] d);
        logic done;
        int   n;
        done = 1'b0;
        n = 0;
        @(negedge clock);
        wr_addr = a;
        wr_data = d;
        wr_en = 1'b1;
        while (!done && n < LIMIT) begin
            #2;
            done = wr_done;
            @(negedge clock);
            n++;
        end
        wr_en = 1'b0;
        if (!done)
            report_timeout("wr_done on a store");
        else
            ref_mem[block_of(a)] = d;
    endtask

    // long enough without bus traffic that fills and write-backs are over
    task automatic wait_quiet();
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet < 16 && n < LIMIT) begin
            @(negedge clock);
            #2;
            if (proc2mem_command == BUS_NONE)
                quiet++;
            else
                quiet = 0;
            n++;
        end
        if (quiet < 16)
            report_timeout("an idle memory bus");
    endtask

    task automatic build_table();
        add_row(OP_LOAD0, 32'h008, 32'h0, 64'h0, 8'd1, NO_CHECK, 1'b0);
        add_row(OP_LOAD1, 32'h008, 32'h0, 64'h0, 8'd1, NO_CHECK, 1'b0);
        add_row(OP_STORE, 32'h008, 32'h0, 64'h1111_2222_3333_4444, NO_CHECK, NO_CHECK, 1'b0);
        add_row(OP_LOAD0, 32'h008, 32'h0, 64'h0, 8'd1, NO_CHECK, 1'b0);
        // store miss, the block is fetched and replaced by the store data
        add_row(OP_STORE, 32'h010, 32'h0, 64'hdead_beef_0bad_f00d, NO_CHECK, NO_CHECK, 1'b0);
        add_row(OP_LOAD1, 32'h010, 32'h0, 64'h0, 8'd1, NO_CHECK, 1'b0);
        add_row(OP_DUAL,  32'h018, 32'h020, 64'h0, 8'd1, NO_CHECK, 1'b0);
        // dirty line in set 5, then a load of another tag pushes it out
        add_row(OP_LOAD0, 32'h028, 32'h0, 64'h0, 8'd1, NO_CHECK, 1'b0);
        add_row(OP_STORE, 32'h028, 32'h0, 64'h0123_4567_89ab_cdef, NO_CHECK, NO_CHECK, 1'b0);
        add_row(OP_LOAD0, 32'h0a8, 32'h0, 64'h0, 8'd1, NO_CHECK, 1'b0);
        add_row(OP_BURST, 32'h030, 32'h038, 64'h0, NO_CHECK, NO_CHECK, 1'b0);
        add_row(OP_BURST, 32'h040, 32'h048, 64'h0, NO_CHECK, NO_CHECK, 1'b0);
        add_row(OP_BURST, 32'h050, 32'h058, 64'h0, NO_CHECK, NO_CHECK, 1'b1);
        for (int k = 0; k < 6; k++)
            add_row((k % 2) ? OP_LOAD1 : OP_LOAD0, 32'h030 + 8 * k, 32'h0, 64'h0, 8'd1,
                    NO_CHECK, 1'b0);
        add_row(OP_DUAL,  32'h060, 32'h060, 64'h0, 8'd1, NO_CHECK, 1'b0);
        add_row(OP_DRAIN, 32'h028, 32'h0, 64'h0, NO_CHECK, 8'd1, 1'b0);
    endtask

    initial begin
        arst_n = 1'b0;
        rd_en = '0;
        rd_addr = '0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        errors = 0;
        checks = 0;
        ready_low_seen = 1'b0;
        for (int b = 0; b < 256; b++)
            ref_mem[b] = {53'h0, b[7:0], 3'b000} ^ PATTERN;
        build_table();
        repeat (16) @(negedge clock);
        arst_n = 1'b1;

        foreach (rows[i]) begin
            cur = rows[i];
            errs_before = errors;
            wait_ready();
            case (cur.op)
                OP_LOAD0: run_loads(2'b01, cur.addr0, cur.addr0, 1'b0);
                OP_LOAD1: run_loads(2'b10, cur.addr0, cur.addr0, 1'b0);
                OP_DUAL:  run_loads(2'b11, cur.addr0, cur.addr1, 1'b0);
                OP_BURST: run_loads(2'b11, cur.addr0, cur.addr1, 1'b1);
                OP_STORE: run_store(cur.addr0, cur.data);
                default: begin
                    wait_quiet();
                    check_value(bus_mem_i.mem[block_of(cur.addr0)], ref_mem[block_of(cur.addr0)],
                                "memory content after write-back");
                end
            endcase
            if (cur.exp_loads != NO_CHECK)
                check_value(bus_mem_i.load_cnt[block_of(cur.addr0)], cur.exp_loads,
                            "BUS_LOAD count");
            if (cur.exp_stores != NO_CHECK)
                check_value(bus_mem_i.store_cnt[block_of(cur.addr0)], cur.exp_stores,
                            "BUS_STORE count");
            if (cur.chk_busy)
                check_value(ready_low_seen, 1'b1, "cache_ready low during the burst");
            $display("row %0d %s %h: %s", i, cur.op.name(), cur.addr0,
                     (errors == errs_before) ? "ok" : "error");
        end

        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- dcache.f
+incdir+design
design/mem_bus_pkg.sv
design/dcache_pkg.sv
design/dcache_ifs.sv
design/dcache_controller.sv
design/dcache_mem.sv
design/mshr.sv
design/dcache_top.sv
testbench/mem_model.sv
testbench/dcache_tb.sv
